// ==== sim/fma_trace.txt ====
// op mod a b c result status, all hex, op 0 FMADD 1 FNMSUB 2 ADD 3 MUL
// status bits are nv of uf nx from MSB to LSB
0 0 4000 4200 3C00 4700 0
0 0 3E00 3E00 3400 4100 0
0 0 3C01 4000 C000 1800 0
0 1 4000 4200 3C00 4500 0
1 0 4000 4200 3C00 C500 0
1 1 4000 4200 3C00 C700 0
2 0 4900 4000 3E00 4300 0
2 1 4900 4000 3E00 3800 0
3 0 4200 3800 4900 3E00 0
3 0 8000 3C00 4900 8000 0
0 0 7C00 0000 7E00 7E00 8
0 0 7C01 3C00 3C00 7E00 8
0 0 7E00 3C00 3C00 7E00 0
0 0 7C00 3C00 FC00 7E00 8
0 0 FC00 4000 3C00 FC00 0
0 0 7BFF 4000 0000 7C00 5
3 0 0001 3A00 0000 0001 3
3 0 0400 3800 0000 0200 0
2 0 0000 3C00 0C00 3C00 1

// ==== project.f ====
+incdir+include
design/fma_pkg.sv
design/fma_operand_prep.sv
design/fma_mant_add.sv
design/fma_pipe_stage.sv
design/fma_normalize_round.sv
design/fma_top.sv
sim/fma_sva.sv
sim/fma_checker.sv
sim/fma_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the FMA testbench with Verilator and run it from the project root
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f project.f --top-module fma_tb -o fma_sim
# Assertion errors must not end the run before the verdict is printed
output=$(./obj_dir/fma_sim +verilator+error+limit+1000 || true)
echo "$output"
if echo "$output" | grep -qx "test passed"; then
  exit 0
fi
exit 1

// ==== sim/fma_tb.sv ====
/*
 * FMA testbench
 * Trace-driven stimulus, random output stalls, watchdog and final verdict
 */
`timescale 1ns/100ps

module fma_tb;

  localparam int unsigned NUM_ENTRIES    = 19;
  localparam int unsigned ENTRY_WORDS    = 7;
  localparam int unsigned CLK_PERIOD     = 20;
  localparam int unsigned RESET_CYCLES   = 4;
  localparam int unsigned TIMEOUT_CYCLES = NUM_ENTRIES * 10 + 20;

  logic                    clk_i;
  logic                    arst_n_i;
  fma_pkg::fp_word_t [2:0] operands_i;
  fma_pkg::fma_op_e        op_i;
  logic                    op_mod_i;
  logic                    in_valid_i;
  logic                    in_ready_o;
  fma_pkg::fp_word_t       result_o;
  fma_pkg::fma_status_t    status_o;
  logic                    out_valid_o;
  logic                    out_ready_i;

  logic [15:0]             trace_mem [0:NUM_ENTRIES*ENTRY_WORDS-1];
  logic [31:0]             lcg_state;
  logic                    checks_done;
  int unsigned             check_errors;
  int unsigned             checked_count;

  fma_top uut (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .operands_i  (operands_i),
    .op_i        (op_i),
    .op_mod_i    (op_mod_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .result_o    (result_o),
    .status_o    (status_o),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i)
  );

  fma_checker #(.NUM_ENTRIES(NUM_ENTRIES)) u_checker (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .out_valid_i     (out_valid_o),
    .out_ready_i     (out_ready_i),
    .result_i        (result_o),
    .status_i        (status_o),
    .done_o          (checks_done),
    .error_count_o   (check_errors),
    .checked_count_o (checked_count)
  );

  // Handshake assertions on the top level ports
  bind fma_top fma_sva u_sva (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .in_valid_i  (in_valid_i),
    .in_ready_i  (in_ready_o),
    .out_valid_i (out_valid_o),
    .out_ready_i (out_ready_i),
    .result_i    (result_o),
    .status_i    (status_o)
  );

  // Numerical Recipes LCG constants
  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // Put one trace entry on the input port
  task automatic drive_entry(input int unsigned idx);
    int unsigned base;
    base = idx * ENTRY_WORDS;
    op_i          <= fma_pkg::fma_op_e'(trace_mem[base][1:0]);
    op_mod_i      <= trace_mem[base+1][0];
    operands_i[0] <= trace_mem[base+2];
    operands_i[1] <= trace_mem[base+3];
    operands_i[2] <= trace_mem[base+4];
    in_valid_i    <= 1'b1;
  endtask

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // --------------------------------------------------------------------------
  // Input side
  // --------------------------------------------------------------------------
  initial begin : stimulus
    arst_n_i   = 1'b0;
    in_valid_i = 1'b0;
    operands_i = '0;
    op_i       = fma_pkg::FMADD;
    op_mod_i   = 1'b0;
    $readmemh("sim/fma_trace.txt", trace_mem);
    repeat (RESET_CYCLES) @(posedge clk_i);
    arst_n_i <= 1'b1;
    for (int unsigned idx = 0; idx < NUM_ENTRIES; idx++) begin
      drive_entry(idx);
      // Hold the entry until an edge sees ready with it
      do begin
        @(posedge clk_i);
      end while (!in_ready_o);
    end
    in_valid_i <= 1'b0;
  end

  // Random back-pressure on the output, about one stall in four
  initial begin : output_stalls
    lcg_state   = 32'h61e7cb28;
    out_ready_i = 1'b0;
    forever begin
      @(posedge clk_i);
      lcg_state = lcg_next(lcg_state);
      out_ready_i <= (lcg_state[31:30] != 2'b00);
    end
  end

  // --------------------------------------------------------------------------
  // End of run
  // --------------------------------------------------------------------------
  initial begin : verdict
    wait (checks_done);
    // One more edge so late duplicates and assertions are seen
    @(posedge clk_i);
    @(negedge clk_i);
    if ((check_errors == 0) && (uut.u_sva.fail_count == 0)) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (TIMEOUT_CYCLES) @(posedge clk_i);
    $display("Timeout after %0d cycles, only %0d of %0d results arrived",
             TIMEOUT_CYCLES, checked_count, NUM_ENTRIES);
    $display("test failed");
    $finish;
  end

endmodule

// ==== sim/fma_checker.sv ====
/*
 * FMA output checker
 * Compares every accepted result and status against the trace, in order
 */
`timescale 1ns/100ps

module fma_checker #(
  parameter int unsigned NUM_ENTRIES = 19
) (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic                 out_valid_i,
  input  logic                 out_ready_i,
  input  fma_pkg::fp_word_t    result_i,
  input  fma_pkg::fma_status_t status_i,
  output logic                 done_o,
  output int unsigned          error_count_o,
  output int unsigned          checked_count_o
);

  localparam int unsigned ENTRY_WORDS = 7;
  localparam int unsigned NUM_GROUPS  = 4;

  logic [15:0] trace_mem [0:NUM_ENTRIES*ENTRY_WORDS-1];
  string       group_name [NUM_GROUPS];
  // Index of the last trace entry in each group
  int unsigned group_last [NUM_GROUPS];
  int unsigned group_idx    = 0;
  int unsigned group_checks = 0;
  int unsigned group_errors = 0;
  int unsigned checked      = 0;
  int unsigned errors       = 0;

  initial begin : load_trace
    $readmemh("sim/fma_trace.txt", trace_mem);
    group_name[0] = "fmadd";
    group_name[1] = "operations";
    group_name[2] = "special cases";
    group_name[3] = "range and flags";
    group_last[0] = 2;
    group_last[1] = 9;
    group_last[2] = 14;
    group_last[3] = 18;
  end

  // --------------------------------------------------------------------------
  // Compare on each output transfer
  // --------------------------------------------------------------------------
  always @(posedge clk_i) begin : compare
    int unsigned          base;
    fma_pkg::fp_word_t    exp_result;
    fma_pkg::fma_status_t exp_status;
    if (arst_n_i && out_valid_i && out_ready_i) begin
      if (checked >= NUM_ENTRIES) begin
        // Anything past the trace is a duplicate or a stray item
        $display("Extra result %h left the DUT at %0t after the last trace entry",
                 result_i, $time);
        errors++;
      end else begin
        base       = checked * ENTRY_WORDS;
        exp_result = trace_mem[base+5];
        exp_status = trace_mem[base+6][3:0];
        group_checks++;
        if ((result_i !== exp_result) || (status_i !== exp_status)) begin
          $display("CHECK FAILED at %0t: entry %0d gave %h flags %b, expected %h flags %b",
                   $time, checked, result_i, status_i, exp_result, exp_status);
          errors++;
          group_errors++;
        end
        // Group line once its last entry is through
        if ((group_idx < NUM_GROUPS) && (checked == group_last[group_idx])) begin
          $display("%s: %0d checked, %0d mismatched",
                   group_name[group_idx], group_checks, group_errors);
          group_idx++;
          group_checks = 0;
          group_errors = 0;
        end
        checked++;
        if (checked == NUM_ENTRIES) begin
          $display("Results: %0d of %0d entries checked, %0d errors",
                   checked, NUM_ENTRIES, errors);
        end
      end
    end
  end

  assign done_o          = (checked == NUM_ENTRIES);
  assign error_count_o   = errors;
  assign checked_count_o = checked;

endmodule

// ==== sim/fma_sva.sv ====
/*
 * FMA handshake assertions
 * Bound to the top level, watches reset, output stability and back-pressure
 */
`timescale 1ns/100ps

module fma_sva (
  input logic                 clk_i,
  input logic                 arst_n_i,
  input logic                 in_valid_i,
  input logic                 in_ready_i,
  input logic                 out_valid_i,
  input logic                 out_ready_i,
  input fma_pkg::fp_word_t    result_i,
  input fma_pkg::fma_status_t status_i
);

  int unsigned fail_count = 0;
  int          occupancy;

  // Items in flight, counted from the transfers at both ends
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      occupancy <= 0;
    end else begin
      occupancy <= occupancy + int'(in_valid_i && in_ready_i)
                   - int'(out_valid_i && out_ready_i);
    end
  end

  // Nothing leaves while reset is held
  reset_quiet: assert property (@(posedge clk_i) !arst_n_i |-> !out_valid_i)
    else begin
      fail_count++;
      $error("out_valid_o high during reset");
    end

  // Stalled output holds its payload
  stall_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (out_valid_i && !out_ready_i) |=> ($stable(result_i) && $stable(status_i)))
    else begin
      fail_count++;
      $error("result or status changed during an output stall");
    end

  stall_keeps_valid: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (out_valid_i && !out_ready_i) |=> out_valid_i)
    else begin
      fail_count++;
      $error("out_valid_o dropped without a transfer");
    end

  // Input stalls only with both stages full and the output blocked
  full_when_stalled: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !in_ready_i |-> ((occupancy == 2) && !out_ready_i))
    else begin
      fail_count++;
      $error("in_ready_o low while the pipeline could accept");
    end

endmodule

// ==== design/fma_top.sv ====
/*
 * FMA top
 * Binary16 fused multiply-add, registered after the adder and at the output
 */
`timescale 1ns/100ps

module fma_top (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  fma_pkg::fp_word_t [2:0] operands_i,
  input  fma_pkg::fma_op_e       op_i,
  input  logic                   op_mod_i,
  input  logic                   in_valid_i,
  output logic                   in_ready_o,
  output fma_pkg::fp_word_t      result_o,
  output fma_pkg::fma_status_t   status_o,
  output logic                   out_valid_o,
  input  logic                   out_ready_i
);

  fma_pkg::fma_prep_t    prep;
  fma_pkg::fma_special_t special;
  fma_pkg::fma_sum_t     sum;
  fma_pkg::fma_mid_t     mid_d, mid_q;
  fma_pkg::fma_out_t     out_d, out_q;
  logic                  mid_valid, mid_ready;

  fma_operand_prep u_operand_prep (
    .operands_i (operands_i),
    .op_i       (op_i),
    .op_mod_i   (op_mod_i),
    .prep_o     (prep),
    .special_o  (special)
  );

  fma_mant_add u_mant_add (
    .prep_i (prep),
    .sum_o  (sum)
  );

  // Adder result and special bypass travel together
  assign mid_d = '{sum: sum, special: special};

  fma_pipe_stage #(.DATA_W($bits(fma_pkg::fma_mid_t))) u_mid_stage (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .valid_i  (in_valid_i),
    .ready_o  (in_ready_o),
    .data_i   (mid_d),
    .valid_o  (mid_valid),
    .ready_i  (mid_ready),
    .data_o   (mid_q)
  );

  fma_normalize_round u_normalize_round (
    .mid_i (mid_q),
    .out_o (out_d)
  );

  fma_pipe_stage #(.DATA_W($bits(fma_pkg::fma_out_t))) u_out_stage (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .valid_i  (mid_valid),
    .ready_o  (mid_ready),
    .data_i   (out_d),
    .valid_o  (out_valid_o),
    .ready_i  (out_ready_i),
    .data_o   (out_q)
  );

  assign result_o = out_q.result;
  assign status_o = out_q.status;

endmodule

// ==== design/fma_normalize_round.sv ====
/*
 * FMA normalize and round
 * Leading-zero count, normalization, RNE rounding, flags and result select
 */
`timescale 1ns/100ps
`include "fma_config.svh"

module fma_normalize_round (
  input  fma_pkg::fma_mid_t mid_i,
  output fma_pkg::fma_out_t out_o
);

  localparam int unsigned P    = `FMA_PREC;
  localparam int unsigned E    = `FMA_EXP_BITS;
  localparam int unsigned M    = `FMA_MAN_BITS;
  localparam int unsigned SW   = `FMA_SUM_BITS;
  localparam int unsigned LW   = `FMA_LZC_BITS;
  localparam int unsigned LZ_W = $clog2(LW);

  fma_pkg::int_exp_t   exp_prod, exp_diff, lz_exp, norm_exp, final_exp;
  fma_pkg::shamt_t     norm_shamt;
  logic [LW-1:0]       sum_lower;
  logic [LZ_W-1:0]     lz_cnt;
  logic                lz_zero;
  logic [SW:0]         sum_shifted;
  logic [P:0]          final_man;
  logic [LW-1:0]       sticky_bits;
  logic                sticky_after_norm;
  logic                of_before, of_after, uf_after;
  logic [E+M-1:0]      pre_abs, rounded_abs;
  logic [1:0]          rs_bits;
  logic                round_up, exact_zero, res_sign;
  fma_pkg::fma_status_t reg_status;

  assign exp_prod  = mid_i.sum.exp_prod;
  assign exp_diff  = mid_i.sum.exp_diff;
  assign sum_lower = mid_i.sum.sum[LW-1:0];

  // Highest set bit wins, scanning up from the LSB
  always_comb begin : lzc
    lz_cnt  = '0;
    lz_zero = 1'b1;
    for (int i = 0; i < LW; i++) begin
      if (sum_lower[i]) begin
        lz_cnt  = LZ_W'(LW - 1 - i);
        lz_zero = 1'b0;
      end
    end
  end

  assign lz_exp = fma_pkg::int_exp_t'({{(`FMA_EXPW-LZ_W){1'b0}}, lz_cnt});

  // ------------------------------------------------------------------------
  // Normalization
  // ------------------------------------------------------------------------
  always_comb begin : norm_shift_amount
    if ((exp_diff <= 0) || (mid_i.sum.eff_sub && (exp_diff <= 2))) begin
      if ((exp_prod - lz_exp + 1 >= 0) && !lz_zero) begin
        // Product anchored or cancelled, drop the counted zeros
        norm_shamt = fma_pkg::shamt_t'(P + 2 + lz_cnt);
        norm_exp   = fma_pkg::int_exp_t'(exp_prod - lz_exp + 1);
      end else begin
        // Subnormal, shift only down to the minimum exponent
        norm_shamt = fma_pkg::shamt_t'(fma_pkg::int_exp_t'(P + 2) + exp_prod);
        norm_exp   = '0;
      end
    end else begin
      // Addend anchored, undo the alignment shift
      norm_shamt = mid_i.sum.addend_shamt;
      norm_exp   = mid_i.sum.tent_exp;
    end
  end

  assign sum_shifted = {1'b0, mid_i.sum.sum} << norm_shamt;

  // One-bit fix-up around the sum MSB
  always_comb begin : small_norm
    {final_man, sticky_bits} = sum_shifted[SW-1:0];
    final_exp                = norm_exp;
    if (sum_shifted[SW]) begin
      {final_man, sticky_bits} = sum_shifted[SW:1];
      final_exp                = norm_exp + fma_pkg::int_exp_t'(1);
    end else if (!sum_shifted[SW-1]) begin
      if (norm_exp > 1) begin
        {final_man, sticky_bits} = {sum_shifted[SW-2:0], 1'b0};
        final_exp                = norm_exp - fma_pkg::int_exp_t'(1);
      end else begin
        final_exp = '0;
      end
    end
  end

  // Right fix-up must not lose the bottom bit
  assign sticky_after_norm = (|sticky_bits) | mid_i.sum.sticky
                             | (sum_shifted[SW] & sum_shifted[0]);

  // ------------------------------------------------------------------------
  // Rounding, nearest even
  // ------------------------------------------------------------------------
  assign of_before = final_exp >= fma_pkg::int_exp_t'((1 << E) - 1);
  // Overflow rounds up from the largest finite value
  assign pre_abs   = of_before ? {{(E-1){1'b1}}, 1'b0, {M{1'b1}}}
                               : {final_exp[E-1:0], final_man[M:1]};
  assign rs_bits   = of_before ? 2'b11 : {final_man[0], sticky_after_norm};
  assign round_up  = rs_bits[1] & (rs_bits[0] | pre_abs[0]);

  assign rounded_abs = pre_abs + (E+M)'(round_up);
  assign exact_zero  = (pre_abs == '0) && (rs_bits == 2'b00);
  // x - x gives +0
  assign res_sign    = (exact_zero && mid_i.sum.eff_sub) ? 1'b0 : mid_i.sum.final_sign;

  assign uf_after = rounded_abs[E+M-1:M] == '0;
  assign of_after = rounded_abs[E+M-1:M] == '1;

  assign reg_status.nv = 1'b0;
  assign reg_status.of = of_before | of_after;
  assign reg_status.nx = (|rs_bits) | of_before | of_after;
  // Tiny after rounding counts only when inexact
  assign reg_status.uf = uf_after & reg_status.nx;

  assign out_o.result = mid_i.special.is_special ? mid_i.special.result
                                                 : {res_sign, rounded_abs};
  assign out_o.status = mid_i.special.is_special ? mid_i.special.status : reg_status;

endmodule

// ==== design/fma_pipe_stage.sv ====
/*
 * Pipe stage
 * One elastic valid/ready register stage for a data vector
 */
`timescale 1ns/100ps

module fma_pipe_stage #(
  parameter int unsigned DATA_W = 8
) (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  logic              valid_i,
  output logic              ready_o,
  input  logic [DATA_W-1:0] data_i,
  output logic              valid_o,
  input  logic              ready_i,
  output logic [DATA_W-1:0] data_o
);

  logic              valid_q;
  logic [DATA_W-1:0] data_q;

  // Accept when empty or when the held item leaves this cycle
  assign ready_o = ready_i | ~valid_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
    end else if (ready_o) begin
      valid_q <= valid_i;
    end
  end

  // Payload loads only on a transfer in
  always_ff @(posedge clk_i) begin
    if (valid_i && ready_o) begin
      data_q <= data_i;
    end
  end

  assign valid_o = valid_q;
  assign data_o  = data_q;

endmodule

// ==== design/fma_mant_add.sv ====
/*
 * FMA mantissa adder
 * Exponent datapath, mantissa product, addend alignment and wide addition
 */
`timescale 1ns/100ps
`include "fma_config.svh"

module fma_mant_add (
  input  fma_pkg::fma_prep_t prep_i,
  output fma_pkg::fma_sum_t  sum_o
);

  localparam int unsigned       P      = `FMA_PREC;
  localparam int unsigned       SW     = `FMA_SUM_BITS;
  localparam fma_pkg::int_exp_t P_E    = fma_pkg::int_exp_t'(`FMA_PREC);
  localparam fma_pkg::int_exp_t BIAS_E = fma_pkg::int_exp_t'(`FMA_BIAS);

  fma_pkg::int_exp_t exp_a, exp_b, exp_c;
  fma_pkg::int_exp_t exp_addend, exp_prod, exp_diff;
  fma_pkg::shamt_t   addend_shamt;
  logic              eff_sub, tent_sign;
  logic [P-1:0]      man_a, man_b, man_c;
  logic [2*P-1:0]    product;
  logic [SW-1:0]     product_shifted, addend_after_shift, addend_shifted;
  logic [P-1:0]      addend_sticky_bits;
  logic              sticky, carry_in;
  logic [SW:0]       sum_raw;

  assign eff_sub   = prep_i.a.sign ^ prep_i.b.sign ^ prep_i.c.sign;
  assign tent_sign = prep_i.a.sign ^ prep_i.b.sign;

  // ------------------------------------------------------------------------
  // Exponents, kept biased
  // ------------------------------------------------------------------------
  assign exp_a = fma_pkg::int_exp_t'({2'b00, prep_i.a.exponent});
  assign exp_b = fma_pkg::int_exp_t'({2'b00, prep_i.b.exponent});
  assign exp_c = fma_pkg::int_exp_t'({2'b00, prep_i.c.exponent});

  // Subnormal or zero addend sits at biased exponent 1
  assign exp_addend = exp_c + fma_pkg::int_exp_t'({6'b0, ~prep_i.info_c.is_normal});
  // Zero product pinned to the minimum exponent
  assign exp_prod = (prep_i.info_a.is_zero || prep_i.info_b.is_zero)
                    ? fma_pkg::int_exp_t'(2) - BIAS_E
                    : exp_a + fma_pkg::int_exp_t'({6'b0, prep_i.info_a.is_subnormal})
                      + exp_b + fma_pkg::int_exp_t'({6'b0, prep_i.info_b.is_subnormal})
                      - BIAS_E;
  assign exp_diff = exp_addend - exp_prod;

  always_comb begin : addend_shift_amount
    if (exp_diff <= -fma_pkg::int_exp_t'(2 * P + 1)) begin
      // Addend only reaches the sticky bit
      addend_shamt = fma_pkg::shamt_t'(3 * P + 4);
    end else if (exp_diff <= P_E + fma_pkg::int_exp_t'(2)) begin
      addend_shamt = fma_pkg::shamt_t'(P_E + fma_pkg::int_exp_t'(3) - exp_diff);
    end else begin
      // Product only reaches the sticky bit
      addend_shamt = '0;
    end
  end

  // ------------------------------------------------------------------------
  // Product and aligned addend
  // ------------------------------------------------------------------------
  assign man_a   = {prep_i.info_a.is_normal, prep_i.a.mantissa};
  assign man_b   = {prep_i.info_b.is_normal, prep_i.b.mantissa};
  assign man_c   = {prep_i.info_c.is_normal, prep_i.c.mantissa};
  assign product = man_a * man_b;

  // Layout  p+2 zeros | 2p product | round and sticky slots
  assign product_shifted = {{(P+2){1'b0}}, product, 2'b00};

  // Addend right shift, up to p bits fall into the sticky field
  assign {addend_after_shift, addend_sticky_bits} = {man_c, {SW{1'b0}}} >> addend_shamt;
  assign sticky         = |addend_sticky_bits;
  assign addend_shifted = eff_sub ? ~addend_after_shift : addend_after_shift;
  // Two's complement carry, unless lost bits make it one short
  assign carry_in       = eff_sub & ~sticky;

  assign sum_raw = product_shifted + addend_shifted + carry_in;

  assign sum_o.eff_sub      = eff_sub;
  assign sum_o.exp_prod     = exp_prod;
  assign sum_o.exp_diff     = exp_diff;
  assign sum_o.tent_exp     = (exp_diff > 0) ? exp_addend : exp_prod;
  assign sum_o.addend_shamt = addend_shamt;
  assign sum_o.sticky       = sticky;
  // No carry out on a subtraction means the sum went negative
  assign sum_o.sum          = (eff_sub && !sum_raw[SW]) ? fma_pkg::sum_vec_t'(-sum_raw)
                                                        : sum_raw[SW-1:0];
  assign sum_o.final_sign   = eff_sub ? (sum_raw[SW] == tent_sign) : tent_sign;

endmodule

// ==== design/fma_operand_prep.sv ====
/*
 * FMA operand preparation
 * Classifies operands, applies opcode sign/constant rules, picks special results
 */
`timescale 1ns/100ps
`include "fma_config.svh"

module fma_operand_prep (
  input  fma_pkg::fp_word_t [2:0] operands_i,
  input  fma_pkg::fma_op_e        op_i,
  input  logic                    op_mod_i,
  output fma_pkg::fma_prep_t      prep_o,
  output fma_pkg::fma_special_t   special_o
);

  localparam int unsigned E = `FMA_EXP_BITS;
  localparam int unsigned M = `FMA_MAN_BITS;
  // Canonical quiet NaN, 7E00
  localparam fma_pkg::fp_word_t QNAN = {1'b0, {E{1'b1}}, 1'b1, {(M-1){1'b0}}};

  fma_pkg::fp16_t    [2:0] raw;
  fma_pkg::fp_info_t [2:0] info;
  fma_pkg::fp16_t          op_a, op_b, op_c;
  fma_pkg::fp_info_t       info_a, info_b, info_c;
  logic                    eff_sub;
  logic                    prod_inf;

  assign raw = operands_i;

  always_comb begin : classify
    for (int i = 0; i < 3; i++) begin
      info[i].is_normal     = (raw[i].exponent != '0) && (raw[i].exponent != '1);
      info[i].is_subnormal  = (raw[i].exponent == '0) && (raw[i].mantissa != '0);
      info[i].is_zero       = (raw[i].exponent == '0) && (raw[i].mantissa == '0);
      info[i].is_inf        = (raw[i].exponent == '1) && (raw[i].mantissa == '0);
      info[i].is_nan        = (raw[i].exponent == '1) && (raw[i].mantissa != '0);
      // Quiet bit is the mantissa MSB
      info[i].is_signalling = info[i].is_nan && !raw[i].mantissa[M-1];
    end
  end

  // ------------------------------------------------------------------------
  // Opcode adjustment
  // ------------------------------------------------------------------------
  always_comb begin : op_select
    op_a   = raw[0];
    op_b   = raw[1];
    op_c   = raw[2];
    info_a = info[0];
    info_b = info[1];
    info_c = info[2];
    // Modifier always negates the addend
    op_c.sign = raw[2].sign ^ op_mod_i;
    unique case (op_i)
      fma_pkg::FMADD: begin
        // Operands pass unchanged
      end
      fma_pkg::FNMSUB: begin
        op_a.sign = ~raw[0].sign;
      end
      fma_pkg::ADD: begin
        // Multiplicand becomes +1.0
        op_a   = '{sign: 1'b0, exponent: E'(`FMA_BIAS), mantissa: '0};
        info_a = '{is_normal: 1'b1, default: 1'b0};
      end
      fma_pkg::MUL: begin
        // Addend becomes -0.0 so a zero product keeps its own sign
        op_c   = '{sign: 1'b1, exponent: '0, mantissa: '0};
        info_c = '{is_zero: 1'b1, default: 1'b0};
      end
    endcase
  end

  assign prep_o   = '{a: op_a, b: op_b, c: op_c, info_a: info_a, info_b: info_b, info_c: info_c};
  assign eff_sub  = op_a.sign ^ op_b.sign ^ op_c.sign;
  assign prod_inf = info_a.is_inf || info_b.is_inf;

  // ------------------------------------------------------------------------
  // Special cases, priority order
  // ------------------------------------------------------------------------
  always_comb begin : special_cases
    special_o.is_special = 1'b1;
    special_o.result     = QNAN;
    special_o.status     = '0;
    if ((info_a.is_inf && info_b.is_zero) || (info_a.is_zero && info_b.is_inf)) begin
      // inf * 0 is invalid even with a quiet NaN addend
      special_o.status.nv = 1'b1;
    end else if (info_a.is_nan || info_b.is_nan || info_c.is_nan) begin
      special_o.status.nv = info_a.is_signalling | info_b.is_signalling | info_c.is_signalling;
    end else if (prod_inf && info_c.is_inf && eff_sub) begin
      special_o.status.nv = 1'b1;
    end else if (prod_inf) begin
      special_o.result = {op_a.sign ^ op_b.sign, {E{1'b1}}, {M{1'b0}}};
    end else if (info_c.is_inf) begin
      special_o.result = {op_c.sign, {E{1'b1}}, {M{1'b0}}};
    end else begin
      special_o.is_special = 1'b0;
    end
  end

endmodule

// ==== design/fma_pkg.sv ====
/*
 * FMA package
 * Opcode, vector and struct types shared by the FMA datapath
 */
`include "fma_config.svh"

package fma_pkg;

  // Opcode, op_mod selects the sub-variant
  typedef enum logic [1:0] {
    FMADD,
    FNMSUB,
    ADD,
    MUL
  } fma_op_e;

  typedef logic [`FMA_WIDTH-1:0]             fp_word_t;
  typedef logic signed [`FMA_EXPW-1:0]       int_exp_t;
  typedef logic [`FMA_SHAMT_BITS-1:0]        shamt_t;
  typedef logic [`FMA_SUM_BITS-1:0]          sum_vec_t;

  typedef struct packed {
    logic                     sign;
    logic [`FMA_EXP_BITS-1:0] exponent;
    logic [`FMA_MAN_BITS-1:0] mantissa;
  } fp16_t;

  typedef struct packed {
    logic is_normal;
    logic is_subnormal;
    logic is_zero;
    logic is_inf;
    logic is_nan;
    logic is_signalling;
  } fp_info_t;

  // IEEE flags, invalid / overflow / underflow / inexact
  typedef struct packed {
    logic nv;
    logic of;
    logic uf;
    logic nx;
  } fma_status_t;

  typedef struct packed {
    logic        is_special;
    fp_word_t    result;
    fma_status_t status;
  } fma_special_t;

  // Operands after opcode adjustment
  typedef struct packed {
    fp16_t    a;
    fp16_t    b;
    fp16_t    c;
    fp_info_t info_a;
    fp_info_t info_b;
    fp_info_t info_c;
  } fma_prep_t;

  // Adder results handed across the middle register
  typedef struct packed {
    logic     eff_sub;
    int_exp_t exp_prod;
    int_exp_t exp_diff;
    int_exp_t tent_exp;
    shamt_t   addend_shamt;
    logic     sticky;
    sum_vec_t sum;
    logic     final_sign;
  } fma_sum_t;

  typedef struct packed {
    fma_sum_t     sum;
    fma_special_t special;
  } fma_mid_t;

  typedef struct packed {
    fp_word_t    result;
    fma_status_t status;
  } fma_out_t;

endpackage

// ==== include/fma_config.svh ====
/*
 * FMA configuration
 * Binary16 format and internal datapath widths of the fused multiply-add
 */
`ifndef FMA_CONFIG_SVH
`define FMA_CONFIG_SVH

// Storage format fields
`define FMA_EXP_BITS   5
`define FMA_MAN_BITS   10
`define FMA_BIAS       15
`define FMA_WIDTH      16

// Precision p, implicit bit included
`define FMA_PREC       11
// Internal sum 3p+4, LZC window 2p+3
`define FMA_SUM_BITS   37
`define FMA_LZC_BITS   25
// Signed internal exponent and shifter control
`define FMA_EXPW       7
`define FMA_SHAMT_BITS 6

`endif
